//--- rtl/exec_pkg.sv
/*
 * Integer execute stage definitions
 * Widths, opcode and function encodings, fault causes and the
 * request, response and decoded-instruction types shared by the stage
 */
`default_nettype none

package exec_pkg;

	// ====================
	// Widths and counts
	// ====================
	localparam int XLEN      = 64;
	localparam int TAG_W     = 6;
	localparam int NUM_LANES = 8;
	localparam int IMM_W     = 24;

	// ====================
	// Opcodes
	// ====================
	localparam logic [7:0] OP_R2     = 8'h02;
	localparam logic [7:0] OP_ADDI   = 8'h04;
	localparam logic [7:0] OP_ANDI   = 8'h08;
	localparam logic [7:0] OP_ORI    = 8'h09;
	localparam logic [7:0] OP_XORI   = 8'h0A;
	localparam logic [7:0] OP_SLTI   = 8'h0C;
	localparam logic [7:0] OP_CHK    = 8'h45;
	localparam logic [7:0] OP_BYTNDX = 8'h55;
	localparam logic [7:0] OP_PERM   = 8'h56;

	// Function codes of the register format, only valid under OP_R2
	localparam logic [3:0] FN_ADD  = 4'h4;
	localparam logic [3:0] FN_SUB  = 4'h5;
	localparam logic [3:0] FN_SLT  = 4'h6;
	localparam logic [3:0] FN_SLTU = 4'h7;
	localparam logic [3:0] FN_AND  = 4'h8;
	localparam logic [3:0] FN_OR   = 4'h9;
	localparam logic [3:0] FN_XOR  = 4'hA;
	localparam logic [3:0] FN_SEQ  = 4'hC;

	// Fault causes reported with each result
	localparam logic [7:0] CAUSE_NONE = 8'h00;
	localparam logic [7:0] CAUSE_UI   = 8'h25;
	localparam logic [7:0] CAUSE_CHK  = 8'h27;

	// Which unit supplies the result of an instruction
	typedef enum logic [1:0] {
		SCALAR,
		BYTE_INDEX,
		BYTE_PERM
	} op_class_e;

	// The opcode sits in the top byte of both formats
	typedef union packed {
		struct packed {
			logic [7:0]  opcode;
			logic [3:0]  func;
			logic [2:0]  chk_mode;
			logic [16:0] spare;
		} r_fmt;
		struct packed {
			logic [7:0]       opcode;
			logic [IMM_W-1:0] imm;
		} i_fmt;
	} instr_u;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		instr_u           instr;
		logic [XLEN-1:0]  a;
		logic [XLEN-1:0]  b;
		logic [XLEN-1:0]  c;
	} exec_req_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0]  res;
		logic [7:0]       cause;
	} exec_rsp_t;

	// Registered output of decode, opnd2 is b or the extended immediate
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		instr_u           instr;
		op_class_e        op_class;
		logic [XLEN-1:0]  a;
		logic [XLEN-1:0]  c;
		logic [XLEN-1:0]  opnd2;
	} dec_t;

endpackage

`default_nettype wire

//--- rtl/exec_byte_lane.sv
/*
 * Byte lane
 * Compares its byte of a against the search key and selects one byte
 * of a for the permute result
 */
`timescale 1ns/100ps
`default_nettype none

module exec_byte_lane #(
	parameter int lane_idx = 0
) (
	input  logic [exec_pkg::XLEN-1:0] a,
	input  logic [exec_pkg::XLEN-1:0] opnd2,
	output logic                      match,
	output logic [7:0]                perm_byte
);

	logic [2:0] sel;

	// The key always lives in the low byte of the second operand
	assign match = a[lane_idx*8 +: 8] == opnd2[7:0];

	// Each lane owns a 3-bit selector field of opnd2
	assign sel       = opnd2[lane_idx*3 +: 3];
	assign perm_byte = a[{sel, 3'b000} +: 8];

endmodule

`default_nettype wire

//--- rtl/exec_decode.sv
/*
 * Execute decode stage
 * Registers an accepted request, classifies the opcode and picks the
 * second operand from b or the sign-extended immediate
 */
`timescale 1ns/100ps
`default_nettype none

module exec_decode (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  exec_pkg::exec_req_t req,
	input  logic                stall,
	output exec_pkg::dec_t      dec,
	output logic                dec_valid
);
	import exec_pkg::*;

	op_class_e       op_class;
	logic            use_imm;
	logic [XLEN-1:0] imm_ext;

	assign imm_ext = {{(XLEN-IMM_W){req.instr.i_fmt.imm[IMM_W-1]}}, req.instr.i_fmt.imm};

	// ====================
	// Opcode classification
	// ====================
	always_comb begin
		op_class = SCALAR;
		use_imm  = 1'b0;
		case (req.instr.r_fmt.opcode)
			OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI: begin
				use_imm = 1'b1;
			end
			// A nonzero func field asks for the immediate as key or selector
			OP_BYTNDX: begin
				op_class = BYTE_INDEX;
				use_imm  = req.instr.r_fmt.func != 4'd0;
			end
			OP_PERM: begin
				op_class = BYTE_PERM;
				use_imm  = req.instr.r_fmt.func != 4'd0;
			end
			default: begin
				op_class = SCALAR;
				use_imm  = 1'b0;
			end
		endcase
	end

	// ====================
	// Pipeline register
	// ====================
	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 1'b0;
		else if (!stall)
			dec_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (!stall && in_valid) begin
			dec.tag      <= req.tag;
			dec.instr    <= req.instr;
			dec.op_class <= op_class;
			dec.a        <= req.a;
			dec.c        <= req.c;
			dec.opnd2    <= use_imm ? imm_ext : req.b;
		end
	end

endmodule

`default_nettype wire

//--- rtl/exec_scalar_alu.sv
/*
 * Scalar ALU
 * Register and immediate arithmetic, logic and compares, the CHK bounds
 * test and undefined-instruction detection
 */
`timescale 1ns/100ps
`default_nettype none

module exec_scalar_alu (
	input  exec_pkg::dec_t              dec,
	output logic [exec_pkg::XLEN-1:0]   res,
	output logic [7:0]                  cause
);
	import exec_pkg::*;

	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic [XLEN-1:0] c;
	logic [2:0]      chk_mode;
	logic            lt_s;
	logic            lt_u;
	logic            a_eq_b;
	logic            c_lt_a;
	logic            lo_ok;
	logic            hi_ok;

	assign a        = dec.a;
	assign b        = dec.opnd2;
	assign c        = dec.c;
	assign chk_mode = dec.instr.r_fmt.chk_mode;

	assign lt_s   = $signed(a) < $signed(b);
	assign lt_u   = a < b;
	assign a_eq_b = a == b;

	// ====================
	// Bounds test c <= a <= b
	// ====================
	// Mode bit 2 picks signed compares, bits 1 and 0 make the bounds exclusive
	assign c_lt_a = chk_mode[2] ? ($signed(c) < $signed(a)) : (c < a);
	assign lo_ok  = c_lt_a || (!chk_mode[0] && c == a);
	assign hi_ok  = (chk_mode[2] ? lt_s : lt_u) || (!chk_mode[1] && a_eq_b);

	always_comb begin
		res   = '0;
		cause = CAUSE_NONE;
		case (dec.instr.r_fmt.opcode)
			OP_R2: begin
				case (dec.instr.r_fmt.func)
					FN_ADD:  res = a + b;
					FN_SUB:  res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_SLT:  res = XLEN'(lt_s);
					FN_SLTU: res = XLEN'(lt_u);
					FN_SEQ:  res = XLEN'(a_eq_b);
					default: cause = CAUSE_UI;
				endcase
			end
			OP_ADDI: res = a + b;
			OP_ANDI: res = a & b;
			OP_ORI:  res = a | b;
			OP_XORI: res = a ^ b;
			OP_SLTI: res = XLEN'(lt_s);
			// CHK writes no value, it only raises a fault
			OP_CHK: begin
				if (!(lo_ok && hi_ok))
					cause = CAUSE_CHK;
			end
			// Byte ops take their result from the lanes
			OP_BYTNDX, OP_PERM: ;
			default: cause = CAUSE_UI;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/exec_result_collect.sv
/*
 * Result collector
 * Merges scalar and byte-lane results into one response, holds it in
 * the output register under back-pressure and raises stall
 */
`timescale 1ns/100ps
`default_nettype none

module exec_result_collect (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                dec_valid,
	input  logic [exec_pkg::TAG_W-1:0]          tag,
	input  exec_pkg::op_class_e                 op_class,
	input  logic [exec_pkg::XLEN-1:0]           scalar_res,
	input  logic [7:0]                          scalar_cause,
	input  logic [exec_pkg::NUM_LANES-1:0]      match,
	input  logic [exec_pkg::NUM_LANES-1:0][7:0] perm_byte,
	input  logic                                out_ready,
	output logic                                out_valid,
	output exec_pkg::exec_rsp_t                 rsp,
	output logic                                stall
);
	import exec_pkg::*;

	logic [XLEN-1:0] ndx_res;
	exec_rsp_t       rsp_nxt;

	// A full output register that is not taken freezes the whole stage
	assign stall = out_valid && !out_ready;

	// ====================
	// Byte index search
	// ====================
	// Walk downward so the lowest matching lane wins, all ones if none
	always_comb begin
		ndx_res = '1;
		for (int i = NUM_LANES - 1; i >= 0; i--) begin
			if (match[i])
				ndx_res = XLEN'(i);
		end
	end

	always_comb begin
		rsp_nxt.tag   = tag;
		rsp_nxt.cause = CAUSE_NONE;
		case (op_class)
			BYTE_INDEX: rsp_nxt.res = ndx_res;
			BYTE_PERM:  rsp_nxt.res = perm_byte;
			default: begin
				rsp_nxt.res   = scalar_res;
				rsp_nxt.cause = scalar_cause;
			end
		endcase
	end

	// ====================
	// Output register
	// ====================
	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (!stall)
			out_valid <= dec_valid;
	end

	always_ff @(posedge clk) begin
		if (!stall && dec_valid)
			rsp <= rsp_nxt;
	end

endmodule

`default_nettype wire

//--- rtl/exec_top.sv
/*
 * Integer execute stage top level
 * Decode register, scalar ALU, eight byte lanes and the result collector
 * joined into a two-cycle valid/ready pipeline
 */
`timescale 1ns/100ps
`default_nettype none

module exec_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	output logic                in_ready,
	input  exec_pkg::exec_req_t in_req,
	output logic                out_valid,
	input  logic                out_ready,
	output exec_pkg::exec_rsp_t out_rsp
);
	import exec_pkg::*;

	dec_t                      dec;
	logic                      dec_valid;
	logic [XLEN-1:0]           scalar_res;
	logic [7:0]                scalar_cause;
	logic [NUM_LANES-1:0]      match;
	logic [NUM_LANES-1:0][7:0] perm_byte;
	logic                      stall;

	// Both stages move together, so the input is open whenever the output is
	assign in_ready = !stall;

	exec_decode u_decode (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.req      (in_req),
		.stall    (stall),
		.dec      (dec),
		.dec_valid(dec_valid)
	);

	exec_scalar_alu u_alu (
		.dec  (dec),
		.res  (scalar_res),
		.cause(scalar_cause)
	);

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		exec_byte_lane #(.lane_idx(i)) u_lane (
			.a        (dec.a),
			.opnd2    (dec.opnd2),
			.match    (match[i]),
			.perm_byte(perm_byte[i])
		);
	end

	exec_result_collect u_collect (
		.clk         (clk),
		.rst         (rst),
		.dec_valid   (dec_valid),
		.tag         (dec.tag),
		.op_class    (dec.op_class),
		.scalar_res  (scalar_res),
		.scalar_cause(scalar_cause),
		.match       (match),
		.perm_byte   (perm_byte),
		.out_ready   (out_ready),
		.out_valid   (out_valid),
		.rsp         (out_rsp),
		.stall       (stall)
	);

endmodule

`default_nettype wire

//--- sim/exec_assert.sv
/*
 * Execute stage handshake assertions
 * Reset state, response hold under back-pressure and the ready rule
 */
`timescale 1ns/100ps
`default_nettype none

module exec_assert (
	input logic                clk,
	input logic                rst,
	input logic                in_ready,
	input logic                out_valid,
	input logic                out_ready,
	input exec_pkg::exec_rsp_t out_rsp
);

	// The output register is empty on the first cycle out of reset
	a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// A stalled response keeps its valid bit and its contents
	a_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_rsp))
		else $error("out_rsp changed while stalled");

	a_ready: assert property (@(posedge clk) disable iff (rst)
		in_ready == !(out_valid && !out_ready))
		else $error("in_ready does not follow the stall rule");

endmodule

bind exec_top exec_assert u_assert (
	.clk      (clk),
	.rst      (rst),
	.in_ready (in_ready),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_rsp  (out_rsp)
);

`default_nettype wire

//--- sim/exec_checker.sv
/*
 * Execute stage checker
 * Predicts each response from its accepted request and compares the
 * responses leaving the DUT in order, latency included
 */
`timescale 1ns/100ps
`default_nettype none

module exec_checker (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  logic                in_ready,
	input  exec_pkg::exec_req_t in_req,
	input  logic                out_valid,
	input  logic                out_ready,
	input  exec_pkg::exec_rsp_t out_rsp,
	output int                  err_count,
	output int                  checks,
	output int                  pending
);
	import exec_pkg::*;

	typedef struct packed {
		exec_rsp_t   rsp;
		logic [31:0] accept_cycle;
	} expect_t;

	expect_t     exp_q [$];
	expect_t     entry;
	expect_t     head;
	logic [31:0] cycle;
	logic [31:0] last_stall;
	logic        rst_q;
	int          errors = 0;
	int          n_checks = 0;
	int          in_flight = 0;

	assign err_count = errors;
	assign checks    = n_checks;
	assign pending   = in_flight;

	// ====================
	// Reference model
	// ====================
	function automatic exec_rsp_t exec_ref(input exec_req_t req);
		exec_rsp_t              rsp;
		logic [7:0]             op;
		logic [3:0]             fn;
		logic [2:0]             mode;
		logic signed [XLEN-1:0] imm;
		logic [XLEN-1:0]        a;
		logic [XLEN-1:0]        b;
		logic [XLEN-1:0]        c;
		logic [XLEN-1:0]        src;
		logic                   lo_ok;
		logic                   hi_ok;
		logic                   found;
		op    = req.instr.i_fmt.opcode;
		fn    = req.instr.r_fmt.func;
		mode  = req.instr.r_fmt.chk_mode;
		imm   = $signed(req.instr.i_fmt.imm);
		a     = req.a;
		b     = req.b;
		c     = req.c;
		src   = (fn != 4'd0) ? imm : b;
		found = 1'b0;
		rsp.tag   = req.tag;
		rsp.res   = '0;
		rsp.cause = CAUSE_NONE;
		case (op)
			OP_R2: begin
				case (fn)
					FN_ADD:  rsp.res = a + b;
					FN_SUB:  rsp.res = a - b;
					FN_AND:  rsp.res = a & b;
					FN_OR:   rsp.res = a | b;
					FN_XOR:  rsp.res = a ^ b;
					FN_SLT:  rsp.res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
					FN_SLTU: rsp.res = (a < b) ? 64'd1 : 64'd0;
					FN_SEQ:  rsp.res = (a == b) ? 64'd1 : 64'd0;
					default: rsp.cause = CAUSE_UI;
				endcase
			end
			OP_ADDI: rsp.res = a + imm;
			OP_ANDI: rsp.res = a & imm;
			OP_ORI:  rsp.res = a | imm;
			OP_XORI: rsp.res = a ^ imm;
			OP_SLTI: rsp.res = ($signed(a) < imm) ? 64'd1 : 64'd0;
			OP_CHK: begin
				if (mode[2]) begin
					lo_ok = mode[0] ? ($signed(c) < $signed(a)) : ($signed(c) <= $signed(a));
					hi_ok = mode[1] ? ($signed(a) < $signed(b)) : ($signed(a) <= $signed(b));
				end else begin
					lo_ok = mode[0] ? (c < a) : (c <= a);
					hi_ok = mode[1] ? (a < b) : (a <= b);
				end
				if (!(lo_ok && hi_ok))
					rsp.cause = CAUSE_CHK;
			end
			OP_BYTNDX: begin
				rsp.res = '1;
				for (int i = 0; i < NUM_LANES; i++) begin
					if (!found && a[i*8 +: 8] == src[7:0]) begin
						rsp.res = XLEN'(i);
						found   = 1'b1;
					end
				end
			end
			OP_PERM: begin
				for (int i = 0; i < NUM_LANES; i++)
					rsp.res[i*8 +: 8] = a[src[i*3 +: 3]*8 +: 8];
			end
			default: rsp.cause = CAUSE_UI;
		endcase
		return rsp;
	endfunction

	task automatic compare_field(input string name, input logic [XLEN-1:0] exp_val,
			input logic [XLEN-1:0] act_val);
		n_checks++;
		if (exp_val !== act_val) begin
			errors++;
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
		end
	endtask

	// ====================
	// Comparison
	// ====================
	always @(posedge clk) begin
		rst_q <= rst;
		if (rst) begin
			exp_q.delete();
			cycle      = 0;
			last_stall = 0;
		end else begin
			cycle = cycle + 1;
			if (rst_q) begin
				compare_field("out_valid", '0, XLEN'(out_valid));
				compare_field("in_ready", XLEN'(1), XLEN'(in_ready));
			end
			if (in_valid && in_ready) begin
				entry.rsp          = exec_ref(in_req);
				entry.accept_cycle = cycle;
				exp_q.push_back(entry);
			end
			if (out_valid && !out_ready)
				last_stall = cycle;
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Error at %0t: response with tag %0d came out with no request",
						$time, out_rsp.tag);
				end else begin
					head = exp_q.pop_front();
					compare_field("out_rsp.tag", XLEN'(head.rsp.tag), XLEN'(out_rsp.tag));
					compare_field("out_rsp.res", head.rsp.res, out_rsp.res);
					compare_field("out_rsp.cause", XLEN'(head.rsp.cause), XLEN'(out_rsp.cause));
					// Without a stall in between the response leaves two edges later
					if (last_stall <= head.accept_cycle)
						compare_field("latency", XLEN'(2), XLEN'(cycle - head.accept_cycle));
					else if (cycle - head.accept_cycle <= 2) begin
						errors++;
						$display("Error at %0t: tag %0d left too early after a stall",
							$time, out_rsp.tag);
					end
				end
			end
			if (exp_q.size() > 2) begin
				errors++;
				$display("Error at %0t: more than two requests in flight", $time);
			end
		end
		in_flight = exp_q.size();
	end

endmodule

`default_nettype wire

//--- sim/exec_tb.sv
/*
 * Execute stage testbench
 * Clock, reset, directed and random requests, and random back-pressure
 * on the response side
 */
`timescale 1ns/100ps
`default_nettype none

module exec_tb;
	import exec_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int NUM_RANDOM = 600;

	logic             clk = 1'b0;
	logic             rst;
	logic             in_valid;
	logic             in_ready;
	exec_req_t        in_req;
	logic             out_valid;
	logic             out_ready;
	exec_rsp_t        out_rsp;
	logic             rand_ready;
	logic [TAG_W-1:0] next_tag;
	int               timeouts;
	int               err_count;
	int               checks;
	int               pending;

	logic [7:0] ops [9] = '{OP_R2, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI,
		OP_CHK, OP_BYTNDX, OP_PERM};
	logic [3:0] fns [8] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU, FN_SEQ};
	logic [7:0] bad_ops [4] = '{8'h00, 8'h03, 8'h44, 8'hFF};
	// Values of a for the bound tests
	// 3 and -8 fall on different sides of the bounds when signed and unsigned
	logic [XLEN-1:0] chk_a [7] = '{64'd50, 64'd3, 64'd8, -64'sd8, 64'd100, 64'd101,
		-64'sd9};

	always #10 clk = ~clk;

	exec_top UUT (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_req   (in_req),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_rsp  (out_rsp)
	);

	exec_checker u_checker (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_req   (in_req),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_rsp  (out_rsp),
		.err_count(err_count),
		.checks   (checks),
		.pending  (pending)
	);

	// Sink is ready three cycles out of four when back-pressure is on
	always @(posedge clk) begin
		if (rand_ready)
			out_ready <= $urandom_range(3) != 0;
		else
			out_ready <= 1'b1;
	end

	// ====================
	// Stimulus helpers
	// ====================
	function automatic exec_req_t make_req(input logic [7:0] opcode);
		exec_req_t req;
		req.tag   = '0;
		req.instr = $urandom;
		req.instr.r_fmt.opcode = opcode;
		if (opcode == OP_R2)
			req.instr.r_fmt.func = fns[$urandom_range(7)];
		if ((opcode == OP_BYTNDX || opcode == OP_PERM) && $urandom_range(1) == 0)
			req.instr.r_fmt.func = 4'd0;
		req.a = {$urandom, $urandom};
		req.b = {$urandom, $urandom};
		req.c = {$urandom, $urandom};
		// Equal operands now and then, to reach the compare and bound edges
		case ($urandom_range(5))
			0: req.b = req.a;
			1: req.c = req.a;
			default: ;
		endcase
		return req;
	endfunction

	task automatic send_req(input exec_req_t req);
		int waited;
		if (timeouts == 0) begin
			req.tag  = next_tag;
			next_tag = next_tag + 1'b1;
			in_valid <= 1'b1;
			in_req   <= req;
			waited = 0;
			do begin
				@(posedge clk);
				waited++;
			end while (!in_ready && waited < WAIT_LIMIT);
			if (!in_ready) begin
				$display("Timeout at %0t: request with tag %0d was never accepted",
					$time, req.tag);
				timeouts++;
			end
			in_valid <= 1'b0;
		end
	endtask

	task automatic directed_reqs();
		exec_req_t  req;
		logic [7:0] key;
		// Every bound mode against inside, on-bound and outside values
		for (int mode = 0; mode < 8; mode++) begin
			for (int k = 0; k < 7; k++) begin
				req = make_req(OP_CHK);
				req.instr.r_fmt.chk_mode = 3'(mode);
				// Signed modes use a lower bound below zero
				req.c = (mode >= 4) ? -64'sd8 : 64'd8;
				req.b = 64'd100;
				req.a = chk_a[k];
				send_req(req);
			end
		end
		// Key planted at one lane, lower lanes differ, higher lanes may repeat it
		for (int src = 0; src < 2; src++) begin
			for (int lane = 0; lane <= NUM_LANES; lane++) begin
				req = make_req(OP_BYTNDX);
				req.instr.r_fmt.func = (src == 0) ? 4'd0 : 4'd7;
				key = 8'($urandom);
				// Only the selected source carries the key
				req.b[7:0] = (src == 0) ? key : ~key;
				req.instr.i_fmt.imm[7:0] = (src == 0) ? ~key : key;
				for (int i = 0; i < NUM_LANES; i++) begin
					if (i < lane)
						req.a[i*8 +: 8] = ~key;
					else if (i == lane || $urandom_range(1) == 1)
						req.a[i*8 +: 8] = key;
				end
				send_req(req);
			end
		end
		foreach (bad_ops[i])
			send_req(make_req(bad_ops[i]));
		for (int f = 0; f < 16; f++) begin
			req = make_req(OP_R2);
			req.instr.r_fmt.func = 4'(f);
			send_req(req);
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (pending != 0 && waited < WAIT_LIMIT);
		if (pending != 0) begin
			$display("Timeout at %0t: %0d responses never came out", $time, pending);
			timeouts++;
		end
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		void'($urandom(32'he102));
		rst        = 1'b1;
		in_valid   = 1'b0;
		in_req     = '0;
		out_ready  = 1'b1;
		rand_ready = 1'b0;
		next_tag   = '0;
		timeouts   = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		// Sink always ready here, so every latency must be exactly two
		directed_reqs();
		rand_ready <= 1'b1;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			send_req(make_req(ops[$urandom_range(8)]));
			if ($urandom_range(7) == 0)
				repeat ($urandom_range(1, 3)) @(posedge clk);
		end
		rand_ready <= 1'b0;
		wait_drain();
		$display("Checks: %0d  errors: %0d  timeouts: %0d", checks, err_count, timeouts);
		if (err_count == 0 && timeouts == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
rtl/exec_pkg.sv
rtl/exec_byte_lane.sv
rtl/exec_decode.sv
rtl/exec_scalar_alu.sv
rtl/exec_result_collect.sv
rtl/exec_top.sv
sim/exec_assert.sv
sim/exec_checker.sv
sim/exec_tb.sv

//--- Makefile
# Verilator build and run for the integer execute stage

VERILATOR  = verilator
TOP        = exec_tb
FILELIST   = compile.f
VFLAGS     = --binary --timing --assert -j 0 --top-module $(TOP)
LINT_FLAGS = --lint-only --timing -Wall --top-module $(TOP)
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass message
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
